// File: src/memPkg.sv
//////////////////////////////////////////////////////////////////////
// Memory stage shared definitions
// Type codes, slot and memory request structs, APB structs, reg map
//////////////////////////////////////////////////////////////////////
`default_nettype none

package memPkg;

    parameter int dataWidth   = 32;                   // Data and address width
    parameter int ldTypeWidth = 3;
    parameter int stTypeWidth = 2;

    // Load type codes as decoded in execute
    localparam logic [ldTypeWidth-1:0] LD_NONE = 3'd0; // No load
    localparam logic [ldTypeWidth-1:0] LD_LB   = 3'd1; // Signed byte
    localparam logic [ldTypeWidth-1:0] LD_LH   = 3'd2; // Signed half
    localparam logic [ldTypeWidth-1:0] LD_LW   = 3'd3; // Word
    localparam logic [ldTypeWidth-1:0] LD_LBU  = 3'd4; // Unsigned byte
    localparam logic [ldTypeWidth-1:0] LD_LHU  = 3'd5; // Unsigned half

    // Store type codes
    localparam logic [stTypeWidth-1:0] ST_NONE = 2'd0; // No store
    localparam logic [stTypeWidth-1:0] ST_SB   = 2'd1;
    localparam logic [stTypeWidth-1:0] ST_SH   = 2'd2;
    localparam logic [stTypeWidth-1:0] ST_SW   = 2'd3;

    // Access width codes
    localparam logic [1:0] WIDTH_BYTE = 2'd0;
    localparam logic [1:0] WIDTH_HALF = 2'd1;
    localparam logic [1:0] WIDTH_WORD = 2'd2;

    // One execute-stage slot
    typedef struct packed {
        logic [ldTypeWidth-1:0] ldType;               // Load type code
        logic [stTypeWidth-1:0] stType;               // Store type code
        logic [dataWidth-1:0]   addr;                 // ALU result
        logic [dataWidth-1:0]   storeData;            // rs2 value
    } memOpT;

    // One data memory access
    typedef struct packed {
        logic                 en;                     // Access this cycle
        logic                 rd;                     // Load, else store
        logic [1:0]           width;                  // Width code
        logic                 sign;                   // Sign-extend load
        logic [dataWidth-1:0] addr;
        logic [dataWidth-1:0] wdata;
    } dmemReqT;

    typedef struct packed {
        logic                 psel;
        logic                 penable;
        logic                 pwrite;
        logic [dataWidth-1:0] paddr;
        logic [dataWidth-1:0] pwdata;
    } apbReqT;

    typedef struct packed {
        logic [dataWidth-1:0] prdata;
        logic                 pready;
        logic                 pslverr;
    } apbRspT;

    // Register byte addresses
    localparam logic [dataWidth-1:0] REG_CTRL  = 32'h0; // Bit 0 is flush
    localparam logic [dataWidth-1:0] REG_LDCNT = 32'h4; // Loads performed
    localparam logic [dataWidth-1:0] REG_STCNT = 32'h8; // Stores performed

endpackage

`default_nettype wire

// File: src/memReqSelect.sv
//////////////////////////////////////////////////////////////////////
// Memory stage request selector
// Merges two slots into one data memory access, slot 0 first
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module memReqSelect (
    input  wire memPkg::memOpT                op0,        // Slot 0 from execute
    input  wire memPkg::memOpT                op1,        // Slot 1 from execute
    input  wire logic                         flush,      // Suppress stores
    input  wire logic [memPkg::dataWidth-1:0] rdata,      // From data memory
    output memPkg::dmemReqT                   req,        // To data memory and CSR
    output logic                              ldEn0,      // Forwarding control
    output logic                              ldEn1,
    output logic                              accessEn0,
    output logic                              accessEn1,
    output logic                              slot1Stall, // Hold slot 1 upstream
    output logic [memPkg::dataWidth-1:0]      ldData0,
    output logic [memPkg::dataWidth-1:0]      ldData1
);
    import memPkg::*;

    logic       stEn0;                                    // Store allowed, slot 0
    logic       stEn1;
    logic [1:0] width0;
    logic [1:0] width1;
    logic       sign0;
    logic       sign1;

    // Width code of a slot, load type wins over store type
    function automatic logic [1:0] opWidth(input logic [ldTypeWidth-1:0] ldType,
                                           input logic [stTypeWidth-1:0] stType);
        logic [1:0] w;
        case (ldType)
            LD_LB, LD_LBU: w = WIDTH_BYTE;
            LD_LH, LD_LHU: w = WIDTH_HALF;
            LD_LW:         w = WIDTH_WORD;
            default: begin
                case (stType)
                    ST_SB:   w = WIDTH_BYTE;
                    ST_SH:   w = WIDTH_HALF;
                    default: w = WIDTH_WORD;              // ST_SW or idle
                endcase
            end
        endcase
        return w;
    endfunction

    // Only LB and LH need sign extension
    function automatic logic opSign(input logic [ldTypeWidth-1:0] ldType);
        return (ldType == LD_LB) || (ldType == LD_LH);
    endfunction

    assign ldEn0 = (op0.ldType != LD_NONE);
    assign ldEn1 = (op1.ldType != LD_NONE);
    assign stEn0 = (op0.stType != ST_NONE) && !flush;     // Flush blocks stores only
    assign stEn1 = (op1.stType != ST_NONE) && !flush;

    assign accessEn0 = ldEn0 || stEn0;
    assign accessEn1 = ldEn1 || stEn1;
    assign slot1Stall = accessEn0 && accessEn1;           // Slot 1 retries next cycle

    assign width0 = opWidth(op0.ldType, op0.stType);
    assign width1 = opWidth(op1.ldType, op1.stType);
    assign sign0  = opSign(op0.ldType);
    assign sign1  = opSign(op1.ldType);

    // Served slot drives the request, idle fields stay zero
    always_comb begin
        req = '0;
        if (accessEn0) begin
            req.en    = 1'b1;
            req.rd    = ldEn0;
            req.width = width0;
            req.sign  = sign0;
            req.addr  = op0.addr;
            req.wdata = op0.storeData;
        end else if (accessEn1) begin
            req.en    = 1'b1;
            req.rd    = ldEn1;
            req.width = width1;
            req.sign  = sign1;
            req.addr  = op1.addr;
            req.wdata = op1.storeData;
        end
    end

    // Read data only reaches the slot actually being served
    assign ldData0 = ldEn0 ? rdata : '0;                  // A load always wins slot 0
    assign ldData1 = (ldEn1 && !accessEn0) ? rdata : '0;

endmodule

`default_nettype wire

// File: src/dataMem.sv
//////////////////////////////////////////////////////////////////////
// Data memory, word array with byte-lane writes
// Combinational reads with lane select and sign or zero extension
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module dataMem #(
    parameter int depth = 256                             // Words
) (
    input  wire logic                         clk,
    input  wire logic                         rstN,
    input  wire memPkg::dmemReqT              req,
    output logic [memPkg::dataWidth-1:0]      rdata
);
    import memPkg::*;

    localparam int idxWidth = (depth > 1) ? $clog2(depth) : 1;

    logic [dataWidth-1:0] memArray [depth];               // No reset on contents
    logic [dataWidth-1:0] wordAddr;
    logic [idxWidth-1:0]  wordIdx;
    logic [3:0]           byteEn;                         // Write lanes
    logic [dataWidth-1:0] wdataLane;                      // Store data moved to lanes
    logic                 wrEn;
    logic [dataWidth-1:0] rdWord;
    logic [7:0]           rdByte;
    logic [15:0]          rdHalf;

    assign wordAddr = req.addr >> 2;                      // Drop byte offset
    assign wordIdx  = idxWidth'(wordAddr % depth);        // Wraps over depth

    // Lane enables and shifted store data
    always_comb begin
        case (req.width)
            WIDTH_BYTE: begin
                byteEn    = 4'b0001 << req.addr[1:0];
                wdataLane = req.wdata << (8 * req.addr[1:0]);
            end
            WIDTH_HALF: begin
                byteEn    = req.addr[1] ? 4'b1100 : 4'b0011; // Bit 0 ignored
                wdataLane = req.wdata << (16 * req.addr[1]);
            end
            WIDTH_WORD: begin
                byteEn    = 4'b1111;
                wdataLane = req.wdata;
            end
            default: begin                                // Unused code writes nothing
                byteEn    = 4'b0000;
                wdataLane = req.wdata;
            end
        endcase
    end

    assign wrEn = rstN && req.en && !req.rd;              // No stores while in reset

    always_ff @(posedge clk) begin
        if (wrEn) begin
            for (int i = 0; i < 4; i++) begin
                if (byteEn[i]) begin
                    memArray[wordIdx][8*i +: 8] <= wdataLane[8*i +: 8];
                end
            end
        end
    end

    // Read path sees contents from before this edge
    assign rdWord = memArray[wordIdx];
    assign rdByte = rdWord[8*req.addr[1:0] +: 8];
    assign rdHalf = req.addr[1] ? rdWord[31:16] : rdWord[15:0];

    always_comb begin
        case (req.width)
            WIDTH_BYTE: begin
                if (req.sign) begin
                    rdata = {{24{rdByte[7]}}, rdByte};
                end else begin
                    rdata = {24'b0, rdByte};
                end
            end
            WIDTH_HALF: begin
                if (req.sign) begin
                    rdata = {{16{rdHalf[15]}}, rdHalf};
                end else begin
                    rdata = {16'b0, rdHalf};
                end
            end
            default: rdata = rdWord;                      // Word, no extension
        endcase
    end

endmodule

`default_nettype wire

// File: src/memCsr.sv
//////////////////////////////////////////////////////////////////////
// Memory stage APB registers
// Flush control plus counters of performed loads and stores
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module memCsr (
    input  wire logic            clk,
    input  wire logic            rstN,
    input  wire memPkg::apbReqT  apbReq,
    input  wire memPkg::dmemReqT req,                     // Access being performed
    output memPkg::apbRspT       apbRsp,
    output logic                 flush                    // To selector
);
    import memPkg::*;

    logic                 apbAccess;                      // Access phase
    logic                 apbWrite;
    logic                 hitCtrl;
    logic                 hitLdCnt;
    logic                 hitStCnt;
    logic                 regHit;                         // Any mapped register
    logic [dataWidth-1:0] ldCnt;
    logic [dataWidth-1:0] stCnt;
    logic [dataWidth-1:0] rdMux;

    assign apbAccess = apbReq.psel && apbReq.penable;
    assign apbWrite  = apbAccess && apbReq.pwrite;

    // Full address compare, no aliasing
    assign hitCtrl  = (apbReq.paddr == REG_CTRL);
    assign hitLdCnt = (apbReq.paddr == REG_LDCNT);
    assign hitStCnt = (apbReq.paddr == REG_STCNT);
    assign regHit   = hitCtrl || hitLdCnt || hitStCnt;

    always_comb begin
        if (hitCtrl) begin
            rdMux = {{(dataWidth-1){1'b0}}, flush};
        end else if (hitLdCnt) begin
            rdMux = ldCnt;
        end else if (hitStCnt) begin
            rdMux = stCnt;
        end else begin
            rdMux = '0;                                   // Unmapped reads zero
        end
    end

    always_comb begin
        apbRsp.prdata  = (apbReq.psel && !apbReq.pwrite) ? rdMux : '0;
        apbRsp.pready  = 1'b1;                            // No wait states
        apbRsp.pslverr = apbAccess && !regHit;
    end

    // Flush bit, seen by selector the cycle after the write
    always_ff @(posedge clk) begin
        if (!rstN) begin
            flush <= 1'b0;
        end else if (apbWrite && hitCtrl) begin
            flush <= apbReq.pwdata[0];
        end
    end

    // Counters wrap, a write of any value clears
    always_ff @(posedge clk) begin
        if (!rstN) begin
            ldCnt <= '0;
            stCnt <= '0;
        end else begin
            if (apbWrite && hitLdCnt) begin
                ldCnt <= '0;                              // Clear wins over count
            end else if (req.en && req.rd) begin
                ldCnt <= ldCnt + 1'b1;
            end
            if (apbWrite && hitStCnt) begin
                stCnt <= '0;
            end else if (req.en && !req.rd) begin
                stCnt <= stCnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/memStage.sv
//////////////////////////////////////////////////////////////////////
// Dual-slot memory stage top level
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module memStage #(
    parameter int memDepth = 256                          // Data memory words
) (
    input  wire logic                         clk,
    input  wire logic                         rstN,
    input  wire memPkg::memOpT                op0,
    input  wire memPkg::memOpT                op1,
    input  wire memPkg::apbReqT               apbReq,
    output memPkg::apbRspT                    apbRsp,
    output logic                              ldEn0,
    output logic                              ldEn1,
    output logic                              accessEn0,
    output logic                              accessEn1,
    output logic                              slot1Stall,
    output logic [memPkg::dataWidth-1:0]      ldData0,
    output logic [memPkg::dataWidth-1:0]      ldData1
);
    import memPkg::*;

    dmemReqT              dmemReq;                        // Selected access
    logic [dataWidth-1:0] memRdata;
    logic                 memFlush;                       // CTRL bit 0

    memReqSelect u_sel (
        .op0        (op0),
        .op1        (op1),
        .flush      (memFlush),
        .rdata      (memRdata),
        .req        (dmemReq),
        .ldEn0      (ldEn0),
        .ldEn1      (ldEn1),
        .accessEn0  (accessEn0),
        .accessEn1  (accessEn1),
        .slot1Stall (slot1Stall),
        .ldData0    (ldData0),
        .ldData1    (ldData1)
    );

    dataMem #(
        .depth (memDepth)
    ) u_mem (
        .clk   (clk),
        .rstN  (rstN),
        .req   (dmemReq),
        .rdata (memRdata)
    );

    memCsr u_csr (
        .clk    (clk),
        .rstN   (rstN),
        .apbReq (apbReq),
        .req    (dmemReq),
        .apbRsp (apbRsp),
        .flush  (memFlush)
    );

endmodule

`default_nettype wire

// File: sim/memStage_sva.sv
//////////////////////////////////////////////////////////////////////
// Memory stage protocol assertions
// Selector stall and flush rules, APB ready, bound at the stage top
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module memStageSva (
    input wire logic                         clk,
    input wire logic                         rstN,
    input wire logic                         accessEn0,
    input wire logic                         accessEn1,
    input wire logic                         slot1Stall,
    input wire logic [memPkg::dataWidth-1:0] ldData1,
    input wire memPkg::dmemReqT              req,         // Selected access
    input wire logic                         flush,
    input wire memPkg::apbRspT               apbRsp
);

    // Stall only when both slots want memory
    stallExact: assert property (@(posedge clk) disable iff (!rstN)
        slot1Stall == (accessEn0 && accessEn1))
        else $error("slot1Stall does not match the two access enables");

    // Flushed stores never reach memory
    noStoreOnFlush: assert property (@(posedge clk) disable iff (!rstN)
        (req.en && flush) |-> req.rd)
        else $error("store access issued while flush is set");

    readyHigh: assert property (@(posedge clk) disable iff (!rstN)
        apbRsp.pready)
        else $error("APB pready low");

    // Slot 1 gets no data while slot 0 holds the port
    ldData1Quiet: assert property (@(posedge clk) disable iff (!rstN)
        accessEn0 |-> (ldData1 == '0))
        else $error("ldData1 nonzero while slot 0 accesses memory");

endmodule

bind memStage memStageSva sva0 (
    .clk        (clk),
    .rstN       (rstN),
    .accessEn0  (accessEn0),
    .accessEn1  (accessEn1),
    .slot1Stall (slot1Stall),
    .ldData1    (ldData1),
    .req        (dmemReq),
    .flush      (memFlush),
    .apbRsp     (apbRsp)
);

`default_nettype wire

// File: sim/memStageTb.sv
//////////////////////////////////////////////////////////////////////
// Memory stage testbench
// LFSR stimulus on both slots and APB, byte model, assertion checks
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module memStageTb;
    import memPkg::*;

    localparam int memDepth     = 64;                     // 64 words or 256 bytes
    localparam int numRoundTrip = 45;
    localparam int numRandom    = 300;
    localparam int numFlush     = 60;
    localparam int numRestore   = 20;
    localparam int numApb       = 15;                     // Transfers in the sequence
    localparam int testCycles   = 3 + numApb * 3 + memDepth + numRoundTrip * 6
                                  + (numRandom + numFlush + numRestore) * 2 + 10;
    localparam int watchdogNs   = testCycles * 10 + 500;
    localparam memOpT idleOp    = '0;

    logic                 clk;
    logic                 rstN;
    memOpT                op0;
    memOpT                op1;
    apbReqT               apbReq;
    apbRspT               apbRsp;
    logic                 ldEn0;
    logic                 ldEn1;
    logic                 accessEn0;
    logic                 accessEn1;
    logic                 slot1Stall;
    logic [dataWidth-1:0] ldData0;
    logic [dataWidth-1:0] ldData1;

    logic [7:0]           modelMem [4*memDepth];          // Byte model of data memory
    logic [dataWidth-1:0] modelLdCnt;
    logic [dataWidth-1:0] modelStCnt;
    logic                 modelFlush;
    logic [31:0]          lfsrState;
    int                   errCount;
    logic                 expLd0;
    logic                 expLd1;
    logic                 expAcc0;
    logic                 expAcc1;
    logic [4:0]           expFlags;
    logic [4:0]           flagsNow;

    memStage #(
        .memDepth (memDepth)
    ) dut0 (
        .clk        (clk),
        .rstN       (rstN),
        .op0        (op0),
        .op1        (op1),
        .apbReq     (apbReq),
        .apbRsp     (apbRsp),
        .ldEn0      (ldEn0),
        .ldEn1      (ldEn1),
        .accessEn0  (accessEn0),
        .accessEn1  (accessEn1),
        .slot1Stall (slot1Stall),
        .ldData0    (ldData0),
        .ldData1    (ldData1)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;                            // 10 ns period
    end

    // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrStep(lfsrState);              // One step per bit
            r = {r[30:0], lfsrState[0]};
        end
        return r;
    endfunction

    function automatic memOpT randomOp();
        memOpT op;
        logic [1:0] kind;
        op   = '0;
        kind = 2'(randBits(2));                           // Idle, store or load
        if (kind == 2'd2) begin
            op.stType = stTypeWidth'(randBits(2) % 3 + 1);
        end else if (kind != 2'd0) begin
            op.ldType = ldTypeWidth'(randBits(3) % 5 + 1);
        end
        op.addr      = randBits(10);                      // Wraps past 64 words
        op.storeData = randBits(32);
        return op;
    endfunction

    function automatic logic slotAccesses(input memOpT op);
        return (op.ldType != LD_NONE) || ((op.stType != ST_NONE) && !modelFlush);
    endfunction

    // Load result from the byte model
    function automatic logic [31:0] expLoad(input logic [ldTypeWidth-1:0] ldType,
                                            input logic [31:0] addr);
        int          base;
        logic [31:0] word;
        logic [7:0]  b;
        logic [15:0] h;
        base = ((addr >> 2) % memDepth) * 4;
        word = {modelMem[base+3], modelMem[base+2], modelMem[base+1], modelMem[base]};
        b    = modelMem[base + addr[1:0]];
        h    = addr[1] ? word[31:16] : word[15:0];        // Bit 0 ignored
        case (ldType)
            LD_LB:   return {{24{b[7]}}, b};
            LD_LBU:  return {24'b0, b};
            LD_LH:   return {{16{h[15]}}, h};
            LD_LHU:  return {16'b0, h};
            default: return word;
        endcase
    endfunction

    function automatic logic [31:0] expReg(input logic [31:0] paddr);
        case (paddr)
            REG_CTRL:  return {31'b0, modelFlush};
            REG_LDCNT: return modelLdCnt;
            REG_STCNT: return modelStCnt;
            default:   return '0;                         // Unmapped
        endcase
    endfunction

    task automatic storeModel(input logic [stTypeWidth-1:0] stType,
                              input logic [31:0] addr, input logic [31:0] data);
        int base;
        base = ((addr >> 2) % memDepth) * 4;
        case (stType)
            ST_SB: modelMem[base + addr[1:0]] = data[7:0];
            ST_SH: begin
                modelMem[base + 2*addr[1]]     = data[7:0];
                modelMem[base + 2*addr[1] + 1] = data[15:8];
            end
            default: begin
                for (int i = 0; i < 4; i++) begin
                    modelMem[base + i] = data[8*i +: 8];
                end
            end
        endcase
    endtask

    task automatic reportMismatch(input string what, input logic [31:0] got,
                                  input logic [31:0] exp);
        $display("MISMATCH at %0t ns: %s got %h, expected %h", $time, what, got, exp);
        errCount++;
    endtask

    task automatic driveOps(input memOpT slot0, input memOpT slot1);
        @(negedge clk);
        op0 = slot0;
        op1 = slot1;
    endtask

    // Setup phase then access phase with both slots idle
    task automatic apbTransfer(input logic write, input logic [31:0] addr,
                               input logic [31:0] data);
        @(negedge clk);
        op0            = idleOp;
        op1            = idleOp;
        apbReq.psel    = 1'b1;
        apbReq.penable = 1'b0;
        apbReq.pwrite  = write;
        apbReq.paddr   = addr;
        apbReq.pwdata  = data;
        @(negedge clk);
        apbReq.penable = 1'b1;
        @(negedge clk);
        apbReq = '0;
    endtask

    // One store followed by every load type at and around its address
    task automatic roundTrip(input logic [stTypeWidth-1:0] stType);
        memOpT st;
        memOpT ld;
        st           = '0;
        st.stType    = stType;
        st.addr      = randBits(10);
        st.storeData = randBits(32);
        driveOps(st, idleOp);
        for (int k = 0; k < 5; k++) begin
            ld        = '0;
            ld.ldType = ldTypeWidth'(k + 1);              // LB through LHU
            ld.addr   = st.addr + (randBits(3) - 32'd3);  // Offsets -3 to +4
            if (randBits(1) != 0) begin
                driveOps(idleOp, ld);                     // Slot 1 alone
            end else begin
                driveOps(ld, idleOp);
            end
        end
    endtask

    task automatic randomTraffic(input int cycles);
        memOpT a;
        memOpT b;
        for (int i = 0; i < cycles; i++) begin
            a = randomOp();
            b = randomOp();
            driveOps(a, b);
            if (slotAccesses(a) && slotAccesses(b)) begin
                driveOps(idleOp, b);                      // Slot 1 held after stall
            end
        end
    endtask

    assign expLd0   = (op0.ldType != LD_NONE);
    assign expLd1   = (op1.ldType != LD_NONE);
    assign expAcc0  = expLd0 || ((op0.stType != ST_NONE) && !modelFlush);
    assign expAcc1  = expLd1 || ((op1.stType != ST_NONE) && !modelFlush);
    assign expFlags = {expLd0, expLd1, expAcc0, expAcc1, expAcc0 && expAcc1};
    assign flagsNow = {ldEn0, ldEn1, accessEn0, accessEn1, slot1Stall};

    flagsCheck: assert property (@(posedge clk) disable iff (!rstN) flagsNow == expFlags)
        else reportMismatch("ldEn/accessEn/stall flags", 32'($sampled(flagsNow)),
                            32'($sampled(expFlags)));

    // Checks against the model before the model takes this edge
    always @(posedge clk) begin : checkAndModel
        memOpT       servedOp;
        logic [31:0] exp0;
        logic [31:0] exp1;
        if (rstN) begin
            exp0 = expLd0 ? expLoad(op0.ldType, op0.addr) : '0;
            exp1 = (expLd1 && !expAcc0) ? expLoad(op1.ldType, op1.addr) : '0;
            ld0Check: assert (ldData0 == exp0) else reportMismatch("ldData0", ldData0, exp0);
            ld1Check: assert (ldData1 == exp1) else reportMismatch("ldData1", ldData1, exp1);
            readyCheck: assert (apbRsp.pready)
                else reportMismatch("pready", 32'(apbRsp.pready), 32'd1);
            if (apbReq.psel && apbReq.penable) begin
                errCheck: assert (apbRsp.pslverr == (expReg(apbReq.paddr) == '0 &&
                        apbReq.paddr != REG_CTRL && apbReq.paddr != REG_LDCNT &&
                        apbReq.paddr != REG_STCNT))
                    else reportMismatch("pslverr", 32'(apbRsp.pslverr), 32'(!apbRsp.pslverr));
                if (!apbReq.pwrite) begin
                    rdCheck: assert (apbRsp.prdata == expReg(apbReq.paddr))
                        else reportMismatch("prdata", apbRsp.prdata, expReg(apbReq.paddr));
                end
            end
            servedOp = expAcc0 ? op0 : op1;               // Slot 0 first
            if (expAcc0 || expAcc1) begin
                if (servedOp.ldType != LD_NONE) begin
                    modelLdCnt++;
                end else begin
                    storeModel(servedOp.stType, servedOp.addr, servedOp.storeData);
                    modelStCnt++;
                end
            end
            if (apbReq.psel && apbReq.penable && apbReq.pwrite) begin
                case (apbReq.paddr)
                    REG_CTRL:  modelFlush = apbReq.pwdata[0];
                    REG_LDCNT: modelLdCnt = '0;           // Clear beats count
                    REG_STCNT: modelStCnt = '0;
                    default:   ;
                endcase
            end
        end
    end

    initial begin : watchdog
        #(watchdogNs);
        $display("Timeout: the test sequence did not finish within %0d ns", watchdogNs);
        $display("Closing count: %0d errors", errCount);
        $display("sim failed");
        $finish;
    end

    initial begin : mainSeq
        memOpT w;
        rstN       = 1'b0;
        op0        = '0;
        op1        = '0;
        apbReq     = '0;
        modelLdCnt = '0;
        modelStCnt = '0;
        modelFlush = 1'b0;
        lfsrState  = 32'd82;                              // Seed
        errCount   = 0;
        repeat (3) @(posedge clk);                        // Reset held for 3 cycles
        @(negedge clk);
        rstN = 1'b1;
        apbTransfer(1'b0, REG_CTRL, '0);                  // Reset values
        apbTransfer(1'b0, REG_LDCNT, '0);
        apbTransfer(1'b0, REG_STCNT, '0);
        for (int i = 0; i < memDepth; i++) begin
            w           = '0;
            w.stType    = ST_SW;
            w.addr      = 32'(i * 4);
            w.storeData = randBits(32);
            driveOps(w, idleOp);                          // Defined contents first
        end
        for (int i = 0; i < numRoundTrip; i++) begin
            roundTrip(stTypeWidth'(i % 3 + 1));
        end
        randomTraffic(numRandom);
        apbTransfer(1'b1, REG_CTRL, 32'd1);               // Flush on
        apbTransfer(1'b0, REG_CTRL, '0);                  // Flush bit reads back
        randomTraffic(numFlush);
        apbTransfer(1'b1, REG_CTRL, 32'd0);
        randomTraffic(numRestore);
        apbTransfer(1'b0, REG_LDCNT, '0);
        apbTransfer(1'b0, REG_STCNT, '0);
        apbTransfer(1'b1, REG_LDCNT, randBits(32));       // Any value clears
        apbTransfer(1'b0, REG_LDCNT, '0);
        apbTransfer(1'b1, REG_STCNT, randBits(32));
        apbTransfer(1'b0, REG_STCNT, '0);
        apbTransfer(1'b0, 32'hC, '0);                     // Unmapped
        apbTransfer(1'b1, 32'h100, randBits(32));
        apbTransfer(1'b0, REG_CTRL, '0);
        driveOps(idleOp, idleOp);
        repeat (2) @(negedge clk);
        $display("Closing count: %0d errors", errCount);
        if (errCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
src/memPkg.sv
src/memReqSelect.sv
src/dataMem.sv
src/memCsr.sv
src/memStage.sv
sim/memStage_sva.sv
sim/memStageTb.sv

// File: Bender.yml
package:
  name: memStage

# RTL in compile order, package first
sources:
  - files:
      - src/memPkg.sv
      - src/memReqSelect.sv
      - src/dataMem.sv
      - src/memCsr.sv
      - src/memStage.sv

  # Bound assertions and the testbench top memStageTb
  - target: simulation
    files:
      - sim/memStage_sva.sv
      - sim/memStageTb.sv
